/* access_steer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mrw_config.svh"

module access_steer (
  input  wire mrw_port_pkg::wr_req_t  wr_req     [`MRW_WR_PORTS],
  input  wire mrw_port_pkg::rd_req_t  rd_req     [`MRW_RD_PORTS],
  output mrw_bank_pkg::vrow_t         lookup_row [`MRW_RD_PORTS+`MRW_WR_PORTS],
  input  wire mrw_bank_pkg::map_row_t lookup_map [`MRW_RD_PORTS+`MRW_WR_PORTS],
  output mrw_bank_pkg::map_upd_t      upd,
  output mrw_bank_pkg::bank_wr_t      bank_wr    [`MRW_PBANKS],
  output mrw_bank_pkg::bank_rd_t      bank_rd    [`MRW_RD_PORTS][`MRW_PBANKS],
  output mrw_bank_pkg::rd_sel_t       rd_sel     [`MRW_RD_PORTS]
);

  localparam int WR1 = `MRW_RD_PORTS + 1;  // Lookup slot of write port 1

  function automatic mrw_bank_pkg::vbank_t addr_vbank(input mrw_port_pkg::addr_t addr);
    return mrw_bank_pkg::vbank_t'(addr);
  endfunction

  function automatic mrw_bank_pkg::vrow_t addr_vrow(input mrw_port_pkg::addr_t addr);
    return mrw_bank_pkg::vrow_t'(addr >> $bits(mrw_bank_pkg::vbank_t));
  endfunction

  // A row's map names all physical banks but one, and that one is free
  function automatic mrw_bank_pkg::pbank_t free_bank(input mrw_bank_pkg::map_row_t row_map);
    logic [`MRW_PBANKS-1:0] used;
    mrw_bank_pkg::pbank_t   free;
    used = '0;
    free = '0;
    for (int v = 0; v < `MRW_VBANKS; v++) begin
      used[row_map[v]] = 1'b1;
    end
    for (int b = `MRW_PBANKS-1; b >= 0; b--) begin
      if (!used[b]) begin
        free = mrw_bank_pkg::pbank_t'(b);
      end
    end
    return free;
  endfunction

  mrw_bank_pkg::vbank_t rd_vbank    [`MRW_RD_PORTS];
  mrw_bank_pkg::vrow_t  rd_vrow     [`MRW_RD_PORTS];
  mrw_bank_pkg::pbank_t rd_pbank    [`MRW_RD_PORTS];
  mrw_bank_pkg::vbank_t wr_vbank    [`MRW_WR_PORTS];
  mrw_bank_pkg::vrow_t  wr_vrow     [`MRW_WR_PORTS];
  mrw_bank_pkg::pbank_t map_pbank   [`MRW_WR_PORTS];
  mrw_bank_pkg::pbank_t place_pbank [`MRW_WR_PORTS];
  mrw_bank_pkg::pbank_t wr1_free;
  logic                 conflict;

  always_comb begin
    for (int p = 0; p < `MRW_RD_PORTS; p++) begin
      rd_vbank[p]   = addr_vbank(rd_req[p].addr);
      rd_vrow[p]    = addr_vrow(rd_req[p].addr);
      lookup_row[p] = rd_vrow[p];
    end
    for (int w = 0; w < `MRW_WR_PORTS; w++) begin
      wr_vbank[w]                   = addr_vbank(wr_req[w].addr);
      wr_vrow[w]                    = addr_vrow(wr_req[w].addr);
      lookup_row[`MRW_RD_PORTS + w] = wr_vrow[w];
    end
  end

  always_comb begin
    for (int p = 0; p < `MRW_RD_PORTS; p++) begin
      rd_pbank[p] = lookup_map[p][rd_vbank[p]];
    end
    for (int w = 0; w < `MRW_WR_PORTS; w++) begin
      map_pbank[w] = lookup_map[`MRW_RD_PORTS + w][wr_vbank[w]];
    end
    wr1_free = free_bank(lookup_map[WR1]);
    // Same-address writes land here too, so port 1 ends up owning the entry
    conflict = wr_req[0].en && wr_req[1].en && (map_pbank[0] == map_pbank[1]);
    place_pbank[0] = map_pbank[0];
    place_pbank[1] = conflict ? wr1_free : map_pbank[1];
    upd.en    = conflict;
    upd.vrow  = wr_vrow[1];
    upd.vbank = wr_vbank[1];
    upd.pbank = wr1_free;
  end

  always_comb begin
    for (int b = 0; b < `MRW_PBANKS; b++) begin
      bank_wr[b] = '0;
      for (int w = 0; w < `MRW_WR_PORTS; w++) begin
        if (wr_req[w].en && (place_pbank[w] == mrw_bank_pkg::pbank_t'(b))) begin
          bank_wr[b].en   = 1'b1;
          bank_wr[b].row  = wr_vrow[w];
          bank_wr[b].data = wr_req[w].data;
        end
      end
      for (int p = 0; p < `MRW_RD_PORTS; p++) begin
        bank_rd[p][b].en  = rd_req[p].en && (rd_pbank[p] == mrw_bank_pkg::pbank_t'(b));
        bank_rd[p][b].row = rd_vrow[p];  // Each port reads only its own copy
      end
    end
    for (int p = 0; p < `MRW_RD_PORTS; p++) begin
      rd_sel[p].vld   = rd_req[p].en;
      rd_sel[p].pbank = rd_pbank[p];
      rd_sel[p].vrow  = rd_vrow[p];
    end
  end

endmodule

`default_nettype wire

/* bank_map.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mrw_config.svh"

module bank_map (
  input  wire logic                   clk,
  input  wire logic                   arst_n,
  input  wire mrw_bank_pkg::vrow_t    lookup_row [`MRW_RD_PORTS+`MRW_WR_PORTS],
  output mrw_bank_pkg::map_row_t      lookup_map [`MRW_RD_PORTS+`MRW_WR_PORTS],
  input  wire mrw_bank_pkg::map_upd_t upd
);

  localparam int LOOKUPS = `MRW_RD_PORTS + `MRW_WR_PORTS;

  mrw_bank_pkg::map_row_t map_q [`MRW_VROWS];

  // Every row starts out with virtual bank v stored in physical bank v
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < `MRW_VROWS; r++) begin
        for (int v = 0; v < `MRW_VBANKS; v++) begin
          map_q[r][v] <= mrw_bank_pkg::pbank_t'(v);
        end
      end
    end else if (upd.en) begin
      map_q[upd.vrow][upd.vbank] <= upd.pbank;  // Only the relocated entry moves
    end
  end

  // Lookups see the map as it stood before this edge
  always_comb begin
    for (int i = 0; i < LOOKUPS; i++) begin
      lookup_map[i] = map_q[lookup_row[i]];
    end
  end

endmodule

`default_nettype wire

/* mrw_bank_pkg.sv */
`default_nettype none

`include "mrw_config.svh"

package mrw_bank_pkg;

  typedef logic [$clog2(`MRW_VBANKS)-1:0] vbank_t;
  typedef logic [$clog2(`MRW_PBANKS)-1:0] pbank_t;
  typedef logic [$clog2(`MRW_VROWS)-1:0]  vrow_t;

  typedef pbank_t [`MRW_VBANKS-1:0] map_row_t;  // Entry v names the home of virtual bank v

  typedef struct packed {
    logic   en;
    vrow_t  vrow;
    vbank_t vbank;
    pbank_t pbank;
  } map_upd_t;

  typedef struct packed {
    logic                en;
    vrow_t               row;
    mrw_port_pkg::data_t data;
  } bank_wr_t;

  typedef struct packed {
    logic  en;
    vrow_t row;
  } bank_rd_t;

  // Everything the gather stage needs to find a read one cycle later
  typedef struct packed {
    logic   vld;
    pbank_t pbank;
    vrow_t  vrow;
  } rd_sel_t;

endpackage

`default_nettype wire

/* mrw_config.svh */
`ifndef MRW_CONFIG_SVH
`define MRW_CONFIG_SVH

// Width of one user data word
`define MRW_DATA_W 16

// Virtual banks are picked by the low address bits
`define MRW_VBANKS 4

// One more physical bank than virtual banks leaves one bank free in every row
`define MRW_PBANKS 5

// Rows per bank, taken from the high address bits
`define MRW_VROWS 64

`define MRW_RD_PORTS 2
`define MRW_WR_PORTS 2

`endif

/* mrw_port_pkg.sv */
`default_nettype none

`include "mrw_config.svh"

package mrw_port_pkg;

  typedef logic [`MRW_DATA_W-1:0] data_t;

  typedef logic [$clog2(`MRW_VBANKS*`MRW_VROWS)-1:0] addr_t;  // Row above, virtual bank below

  typedef logic [$clog2(`MRW_PBANKS)+$clog2(`MRW_VROWS)-1:0] padr_t;  // Physical bank above row

  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } wr_req_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic  vld;
    data_t data;
    padr_t padr;
  } rd_rsp_t;

endpackage

`default_nettype wire

/* mrw_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mrw_config.svh"

module mrw_tb;

  localparam int PERIOD      = 100;
  localparam int DRIVE_DLY   = 5;
  localparam int RST_CYCLES  = 8;
  localparam int RAND_CYCLES = 300;
  localparam int ADDRS       = `MRW_VBANKS * `MRW_VROWS;

  localparam mrw_port_pkg::wr_req_t WR_IDLE = '0;
  localparam mrw_port_pkg::rd_req_t RD_IDLE = '0;

  logic                  clk;
  logic                  arst_n;
  mrw_port_pkg::wr_req_t wr_req [`MRW_WR_PORTS];
  mrw_port_pkg::rd_req_t rd_req [`MRW_RD_PORTS];
  mrw_port_pkg::rd_rsp_t rd_rsp [`MRW_RD_PORTS];

  mrw_port_pkg::data_t  ref_mem   [ADDRS];
  logic                 ref_known [ADDRS];  // Set once an address has been written
  mrw_bank_pkg::pbank_t ref_map   [`MRW_VROWS][`MRW_VBANKS];

  // Expected responses for the reads driven in the current cycle
  logic                exp_vld   [`MRW_RD_PORTS];
  logic                exp_known [`MRW_RD_PORTS];
  mrw_port_pkg::data_t exp_data  [`MRW_RD_PORTS];
  mrw_port_pkg::padr_t exp_padr  [`MRW_RD_PORTS];

  mrw_top dut0 (
    .clk    (clk),
    .arst_n (arst_n),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("Something failed");
    $fatal(1, "%s", why);
  endtask

  task automatic compare_vld(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s vld is %b, expected %b", $time, what, got, exp);
      stop_run("response valid mismatch");
    end
  endtask

  task automatic compare_data(input mrw_port_pkg::data_t got, input mrw_port_pkg::data_t exp,
                              input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s data is %h, expected %h", $time, what, got, exp);
      stop_run("read data mismatch");
    end
  endtask

  task automatic compare_padr(input mrw_port_pkg::padr_t got, input mrw_port_pkg::padr_t exp,
                              input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s padr is %h, expected %h", $time, what, got, exp);
      stop_run("physical address mismatch");
    end
  endtask

  function automatic mrw_port_pkg::wr_req_t wr_of(input mrw_port_pkg::addr_t addr,
                                                  input mrw_port_pkg::data_t data);
    mrw_port_pkg::wr_req_t req;
    req.en   = 1'b1;
    req.addr = addr;
    req.data = data;
    return req;
  endfunction

  function automatic mrw_port_pkg::rd_req_t rd_of(input mrw_port_pkg::addr_t addr);
    mrw_port_pkg::rd_req_t req;
    req.en   = 1'b1;
    req.addr = addr;
    return req;
  endfunction

  // The free bank is the only physical bank that no virtual bank of the row points at
  function automatic mrw_bank_pkg::pbank_t model_free(input mrw_bank_pkg::vrow_t row);
    logic taken;
    for (int b = 0; b < `MRW_PBANKS; b++) begin
      taken = 1'b0;
      for (int v = 0; v < `MRW_VBANKS; v++) begin
        if (ref_map[row][v] == mrw_bank_pkg::pbank_t'(b)) begin
          taken = 1'b1;
        end
      end
      if (!taken) begin
        return mrw_bank_pkg::pbank_t'(b);
      end
    end
    return '0;
  endfunction

  task automatic model_step(input mrw_port_pkg::wr_req_t w0, input mrw_port_pkg::wr_req_t w1,
                            input mrw_port_pkg::rd_req_t r0, input mrw_port_pkg::rd_req_t r1);
    mrw_port_pkg::rd_req_t r   [2];
    mrw_port_pkg::wr_req_t w   [2];
    mrw_bank_pkg::pbank_t  pb  [2];
    mrw_bank_pkg::vrow_t   row;
    r[0] = r0;
    r[1] = r1;
    w[0] = w0;
    w[1] = w1;
    for (int p = 0; p < 2; p++) begin  // Reads see memory and map before this edge's writes
      row          = r[p].addr[7:2];
      exp_vld[p]   = r[p].en;
      exp_known[p] = ref_known[r[p].addr];
      exp_data[p]  = ref_mem[r[p].addr];
      exp_padr[p]  = {ref_map[row][r[p].addr[1:0]], row};
    end
    for (int i = 0; i < 2; i++) begin
      pb[i] = ref_map[w[i].addr[7:2]][w[i].addr[1:0]];
    end
    if (w[0].en && w[1].en && pb[0] == pb[1]) begin
      ref_map[w[1].addr[7:2]][w[1].addr[1:0]] = model_free(w[1].addr[7:2]);
    end
    for (int i = 0; i < 2; i++) begin  // Port 1 last, so it wins on the same address
      if (w[i].en) begin
        ref_mem[w[i].addr]   = w[i].data;
        ref_known[w[i].addr] = 1'b1;
      end
    end
  endtask

  task automatic check_rsp();
    for (int p = 0; p < 2; p++) begin
      compare_vld(rd_rsp[p].vld, exp_vld[p], $sformatf("port %0d", p));
      if (exp_vld[p]) begin
        compare_padr(rd_rsp[p].padr, exp_padr[p], $sformatf("port %0d", p));
        if (exp_known[p]) begin
          compare_data(rd_rsp[p].data, exp_data[p], $sformatf("port %0d", p));
        end
      end
    end
  endtask

  // Drives one cycle of requests and checks their responses one edge later
  task automatic cycle(input mrw_port_pkg::wr_req_t w0, input mrw_port_pkg::wr_req_t w1,
                       input mrw_port_pkg::rd_req_t r0, input mrw_port_pkg::rd_req_t r1);
    wr_req[0] = w0;
    wr_req[1] = w1;
    rd_req[0] = r0;
    rd_req[1] = r1;
    model_step(w0, w1, r0, r1);
    @(posedge clk);
    #DRIVE_DLY;
    check_rsp();
  endtask

  task automatic test_reset();
    for (int c = 0; c < RST_CYCLES; c++) begin
      @(posedge clk);
      #DRIVE_DLY;
      compare_vld(rd_rsp[0].vld, 1'b0, "port 0 in reset");
      compare_vld(rd_rsp[1].vld, 1'b0, "port 1 in reset");
    end
    arst_n = 1'b1;
  endtask

  task automatic test_single_write();
    cycle(wr_of(8'h25, 16'hA5C3), WR_IDLE, RD_IDLE, RD_IDLE);
    cycle(WR_IDLE, WR_IDLE, rd_of(8'h25), rd_of(8'h25));
    compare_padr(rd_rsp[0].padr, {3'd1, 6'd9}, "port 0 after single write");
    compare_data(rd_rsp[1].data, 16'hA5C3, "port 1 after single write");
  endtask

  task automatic test_write_conflict();
    cycle(wr_of(8'h0E, 16'h1111), wr_of(8'h2A, 16'h2222), RD_IDLE, RD_IDLE);
    cycle(WR_IDLE, WR_IDLE, rd_of(8'h0E), rd_of(8'h2A));
    compare_padr(rd_rsp[1].padr, {3'd4, 6'd10}, "write 1 moved to free bank");
    // Row 10 gave up bank 2, so the next clash in that row must land there
    cycle(wr_of(8'h14, 16'h3333), wr_of(8'h28, 16'h4444), RD_IDLE, RD_IDLE);
    cycle(WR_IDLE, WR_IDLE, rd_of(8'h14), rd_of(8'h28));
    compare_padr(rd_rsp[1].padr, {3'd2, 6'd10}, "former bank reused");
  endtask

  task automatic test_same_address();
    cycle(wr_of(8'h11, 16'hAAAA), wr_of(8'h11, 16'hBBBB), RD_IDLE, RD_IDLE);
    cycle(WR_IDLE, WR_IDLE, rd_of(8'h11), rd_of(8'h11));
    compare_data(rd_rsp[0].data, 16'hBBBB, "port 0 same-address write");
  endtask

  task automatic test_read_during_write();
    cycle(wr_of(8'h33, 16'h0F0F), WR_IDLE, RD_IDLE, RD_IDLE);
    cycle(wr_of(8'h33, 16'hF0F0), WR_IDLE, rd_of(8'h33), RD_IDLE);
    compare_data(rd_rsp[0].data, 16'h0F0F, "read beside write");
    cycle(WR_IDLE, WR_IDLE, rd_of(8'h33), rd_of(8'h33));
    compare_data(rd_rsp[1].data, 16'hF0F0, "read after write");
  endtask

  task automatic test_random();
    mrw_port_pkg::wr_req_t w [2];
    mrw_port_pkg::rd_req_t r [2];
    for (int c = 0; c < RAND_CYCLES; c++) begin
      for (int i = 0; i < 2; i++) begin  // 16 rows only, so clashes and relocations pile up
        w[i].en   = 1'($urandom_range(0, 1));
        w[i].addr = mrw_port_pkg::addr_t'($urandom_range(0, 63));
        w[i].data = mrw_port_pkg::data_t'($urandom);
        r[i].en   = 1'($urandom_range(0, 1));
        r[i].addr = mrw_port_pkg::addr_t'($urandom_range(0, 63));
      end
      cycle(w[0], w[1], r[0], r[1]);
    end
  endtask

  initial begin
    void'($urandom(84));
    arst_n = 1'b0;
    for (int p = 0; p < 2; p++) begin
      wr_req[p]    = '0;
      rd_req[p]    = '0;
      exp_vld[p]   = 1'b0;
      exp_known[p] = 1'b0;
      exp_data[p]  = '0;
      exp_padr[p]  = '0;
    end
    for (int a = 0; a < ADDRS; a++) begin
      ref_mem[a]   = '0;
      ref_known[a] = 1'b0;
    end
    for (int r = 0; r < `MRW_VROWS; r++) begin
      for (int v = 0; v < `MRW_VBANKS; v++) begin
        ref_map[r][v] = mrw_bank_pkg::pbank_t'(v);
      end
    end
    test_reset();
    test_single_write();
    test_write_conflict();
    test_same_address();
    test_read_during_write();
    test_random();
    cycle(WR_IDLE, WR_IDLE, RD_IDLE, RD_IDLE);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* mrw_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mrw_config.svh"

module mrw_top (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire mrw_port_pkg::wr_req_t wr_req [`MRW_WR_PORTS],
  input  wire mrw_port_pkg::rd_req_t rd_req [`MRW_RD_PORTS],
  output mrw_port_pkg::rd_rsp_t      rd_rsp [`MRW_RD_PORTS]
);

  mrw_bank_pkg::vrow_t    lookup_row [`MRW_RD_PORTS+`MRW_WR_PORTS];
  mrw_bank_pkg::map_row_t lookup_map [`MRW_RD_PORTS+`MRW_WR_PORTS];
  mrw_bank_pkg::map_upd_t upd;
  mrw_bank_pkg::bank_wr_t bank_wr    [`MRW_PBANKS];
  mrw_bank_pkg::bank_rd_t bank_rd    [`MRW_RD_PORTS][`MRW_PBANKS];
  mrw_bank_pkg::rd_sel_t  rd_sel     [`MRW_RD_PORTS];
  mrw_port_pkg::data_t    bank_data  [`MRW_RD_PORTS][`MRW_PBANKS];

  bank_map map0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .lookup_row (lookup_row),
    .lookup_map (lookup_map),
    .upd        (upd)
  );

  access_steer steer0 (
    .wr_req     (wr_req),
    .rd_req     (rd_req),
    .lookup_row (lookup_row),
    .lookup_map (lookup_map),
    .upd        (upd),
    .bank_wr    (bank_wr),
    .bank_rd    (bank_rd),
    .rd_sel     (rd_sel)
  );

  // One full set of physical banks per read port, all fed the same writes
  for (genvar p = 0; p < `MRW_RD_PORTS; p++) begin : port_loop
    for (genvar b = 0; b < `MRW_PBANKS; b++) begin : bank_loop
      phys_bank bank0 (
        .clk     (clk),
        .wr      (bank_wr[b]),
        .rd      (bank_rd[p][b]),
        .rd_data (bank_data[p][b])
      );
    end
  end

  read_gather gather0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_sel    (rd_sel),
    .bank_data (bank_data),
    .rd_rsp    (rd_rsp)
  );

endmodule

`default_nettype wire

/* phys_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mrw_config.svh"

module phys_bank (
  input  wire logic                   clk,
  input  wire mrw_bank_pkg::bank_wr_t wr,
  input  wire mrw_bank_pkg::bank_rd_t rd,
  output mrw_port_pkg::data_t         rd_data
);

  mrw_port_pkg::data_t mem [`MRW_VROWS];

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.row] <= wr.data;
    end
  end

  // A read of the row being written sees the old word
  always_ff @(posedge clk) begin
    if (rd.en) begin
      rd_data <= mem[rd.row];
    end
  end

endmodule

`default_nettype wire

/* read_gather.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mrw_config.svh"

module read_gather (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire mrw_bank_pkg::rd_sel_t rd_sel    [`MRW_RD_PORTS],
  input  wire mrw_port_pkg::data_t   bank_data [`MRW_RD_PORTS][`MRW_PBANKS],
  output mrw_port_pkg::rd_rsp_t      rd_rsp    [`MRW_RD_PORTS]
);

  mrw_bank_pkg::rd_sel_t sel_q [`MRW_RD_PORTS];

  // Lines up with the registered read inside the banks
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int p = 0; p < `MRW_RD_PORTS; p++) begin
        sel_q[p] <= '0;
      end
    end else begin
      for (int p = 0; p < `MRW_RD_PORTS; p++) begin
        sel_q[p] <= rd_sel[p];
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `MRW_RD_PORTS; p++) begin
      rd_rsp[p].vld  = sel_q[p].vld;
      rd_rsp[p].data = bank_data[p][sel_q[p].pbank];  // Port p only ever reads its own copies
      rd_rsp[p].padr = {sel_q[p].pbank, sel_q[p].vrow};
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status tells pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module mrw_tb -o mrw_sim \
  && ./obj_dir/mrw_sim \
  || { echo "build or simulation did not succeed"; exit 1; }

/* src.f */
+incdir+.
mrw_port_pkg.sv
mrw_bank_pkg.sv
bank_map.sv
access_steer.sv
phys_bank.sv
read_gather.sv
mrw_top.sv
mrw_tb.sv
